//--- Makefile
# Verilator build and run of the stream to AXI-lite write bridge testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_axis_to_lite_wr
FILELIST  := axis_to_lite_wr.f
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a listed source or the list itself changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- axis_to_lite_wr.f
hw/axis_lite_pkg.sv
hw/field_beat_counter.sv
hw/field_assembler.sv
hw/lite_write_fsm.sv
hw/axis_to_lite_wr.sv
verif/lite_slave_model.sv
verif/tb_axis_to_lite_wr.sv

//--- hw/axis_lite_pkg.sv
/*
 * shared types for the byte stream to AXI-lite write bridge
 * every RTL block imports this package; it carries the stream beat,
 * the decoded write request and the state encoding of the write FSM
 */
package axis_lite_pkg;

    // one stream byte
    typedef logic [7:0] byte_t;

    // AXI-lite address and write data
    typedef logic [31:0] addr_t;
    typedef logic [31:0] wdata_t;

    // AXI response code, write side only
    typedef logic [1:0] resp_t;

    // anything else (SLVERR, DECERR, EXOKAY) is flagged as an error
    localparam resp_t RESP_OKAY = 2'b00;

    // byte counter, wide enough for an 8 byte field plus saturation
    typedef logic [3:0] beat_cnt_t;

    // one beat on the byte stream
    typedef struct packed {
        byte_t tdata;
        logic  tlast;
    } axis_beat_t;

    // one decoded write, address and data taken from the packet field
    typedef struct packed {
        addr_t  addr;
        wdata_t data;
    } write_req_t;

    // write FSM
    // idle accepts stream bytes, issue drives aw and w, resp waits for b
    typedef enum logic [1:0] {
        WR_IDLE  = 2'd0,
        WR_ISSUE = 2'd1,
        WR_RESP  = 2'd2
    } wr_state_t;

endpackage

//--- hw/axis_to_lite_wr.sv
/*
 * top of the byte stream to AXI-lite write bridge
 * a packet brings ADDR_BYTES of address then 4 data bytes, msb first;
 * each complete packet becomes one write, short packets pulse short_pkt
 */
`timescale 1ns/1ps

module axis_to_lite_wr #(
    parameter int ADDR_BYTES = 4
) (
    input  logic                      aclk,
    input  logic                      rst_n,
    // byte stream in
    input  logic                      s_axis_tvalid,
    input  axis_lite_pkg::axis_beat_t s_axis_beat,
    output logic                      s_axis_tready,
    // AXI-lite write master
    output logic                      axi_awvalid,
    input  logic                      axi_awready,
    output axis_lite_pkg::addr_t      axi_awaddr,
    output logic                      axi_wvalid,
    input  logic                      axi_wready,
    output axis_lite_pkg::wdata_t     axi_wdata,
    input  logic                      axi_bvalid,
    input  axis_lite_pkg::resp_t      axi_bresp,
    output logic                      axi_bready,
    // status pulses
    output logic                      wr_done,
    output logic                      wr_err,
    output logic                      short_pkt
);
    import axis_lite_pkg::*;

    logic       beat_accept;
    logic       take_byte;
    logic       pkt_done;
    write_req_t req;

    // byte transfers on valid and ready
    assign beat_accept = s_axis_tvalid && s_axis_tready;

    field_beat_counter #(
        .ADDR_BYTES (ADDR_BYTES)
    ) u_counter (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .beat_accept (beat_accept),
        .beat_last   (s_axis_beat.tlast),
        .take_byte   (take_byte),
        .pkt_done    (pkt_done),
        .short_pkt   (short_pkt)
    );

    field_assembler #(
        .ADDR_BYTES (ADDR_BYTES)
    ) u_assembler (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .take_byte (take_byte),
        .beat      (s_axis_beat),
        .req       (req)
    );

    lite_write_fsm u_write_fsm (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .pkt_done      (pkt_done),
        .req           (req),
        .s_axis_tready (s_axis_tready),
        .axi_awvalid   (axi_awvalid),
        .axi_awready   (axi_awready),
        .axi_awaddr    (axi_awaddr),
        .axi_wvalid    (axi_wvalid),
        .axi_wready    (axi_wready),
        .axi_wdata     (axi_wdata),
        .axi_bvalid    (axi_bvalid),
        .axi_bresp     (axi_bresp),
        .axi_bready    (axi_bready),
        .wr_done       (wr_done),
        .wr_err        (wr_err)
    );

endmodule

//--- hw/field_assembler.sv
/*
 * collects the field bytes of a packet, msb first, into one write request
 * bytes are shifted in while take_byte is high; the request is stable from
 * the edge after the last field byte until the next field starts
 */
`timescale 1ns/1ps

module field_assembler #(
    parameter int ADDR_BYTES = 4
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     take_byte,
    input  axis_lite_pkg::axis_beat_t beat,
    output axis_lite_pkg::write_req_t req
);
    import axis_lite_pkg::*;

    // keeps only the address bytes that the field actually carries
    localparam addr_t ADDR_MASK = addr_t'((64'd1 << (ADDR_BYTES * 8)) - 64'd1);

    // field shift register, newest byte in the low byte lane
    logic [63:0] field_sr;
    addr_t       raw_addr;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            field_sr <= '0;
        end else if (take_byte) begin
            field_sr <= {field_sr[55:0], beat.tdata};
        end
    end

    // after the full field the low 4 bytes are the data word
    // and the address bytes sit right above them
    assign raw_addr = field_sr[63:32];

    // bytes above the address field may still hold
    // older packet bytes, so they are forced to zero
    always_comb begin
        req.addr = raw_addr & ADDR_MASK;
        req.data = field_sr[31:0];
    end

endmodule

//--- hw/field_beat_counter.sv
/*
 * counts accepted stream bytes of a packet and marks the bytes that
 * belong to the address/data field; at tlast it reports whether the
 * packet carried the full field (pkt_done) or ended early (short_pkt)
 */
`timescale 1ns/1ps

module field_beat_counter #(
    parameter int ADDR_BYTES = 4
) (
    input  logic aclk,
    input  logic rst_n,
    input  logic beat_accept,
    input  logic beat_last,
    output logic take_byte,
    output logic pkt_done,
    output logic short_pkt
);
    import axis_lite_pkg::*;

    // address bytes followed by four data bytes
    localparam beat_cnt_t FIELD_LEN = beat_cnt_t'(ADDR_BYTES + 4);

    beat_cnt_t cnt;
    logic      in_field;
    logic      field_full;

    // position of the current byte is still inside the field
    assign in_field  = (cnt < FIELD_LEN);
    assign take_byte = beat_accept && in_field;

    // the field is complete once this beat is counted
    assign field_full = (cnt >= FIELD_LEN - beat_cnt_t'(1));

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            pkt_done  <= 1'b0;
            short_pkt <= 1'b0;
        end else begin
            // both flags are single cycle pulses
            pkt_done  <= 1'b0;
            short_pkt <= 1'b0;
            if (beat_accept) begin
                if (beat_last) begin
                    // next packet starts from zero
                    cnt <= '0;
                    if (field_full) begin
                        pkt_done <= 1'b1;
                    end else begin
                        short_pkt <= 1'b1;
                    end
                end else if (in_field) begin
                    // trailing bytes leave the count saturated at the field length
                    cnt <= cnt + beat_cnt_t'(1);
                end
            end
        end
    end

endmodule

//--- hw/lite_write_fsm.sv
/*
 * issues one AXI-lite write per completed packet
 * aw and w are driven independently, each held until its own ready;
 * the stream is stalled from the start of the write until the b response
 */
`timescale 1ns/1ps

module lite_write_fsm (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      pkt_done,
    input  axis_lite_pkg::write_req_t req,
    output logic                      s_axis_tready,
    // write address channel
    output logic                      axi_awvalid,
    input  logic                      axi_awready,
    output axis_lite_pkg::addr_t      axi_awaddr,
    // write data channel
    output logic                      axi_wvalid,
    input  logic                      axi_wready,
    output axis_lite_pkg::wdata_t     axi_wdata,
    // write response channel
    input  logic                      axi_bvalid,
    input  axis_lite_pkg::resp_t      axi_bresp,
    output logic                      axi_bready,
    output logic                      wr_done,
    output logic                      wr_err
);
    import axis_lite_pkg::*;

    wr_state_t state;

    // phase finished flags, one per channel
    logic aw_done;
    logic w_done;

    logic aw_fin;
    logic w_fin;

    // a phase counts as finished on its handshake edge too
    assign aw_fin = aw_done || (axi_awvalid && axi_awready);
    assign w_fin  = w_done || (axi_wvalid && axi_wready);

    // bytes only flow while no write is pending
    assign s_axis_tready = (state == WR_IDLE);

    // single outstanding write, so b is always taken
    assign axi_bready = 1'b1;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= WR_IDLE;
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            wr_done     <= 1'b0;
            wr_err      <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            wr_err  <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (pkt_done) begin
                        // start both phases together
                        axi_awvalid <= 1'b1;
                        axi_wvalid  <= 1'b1;
                        aw_done     <= 1'b0;
                        w_done      <= 1'b0;
                        state       <= WR_ISSUE;
                    end
                end
                WR_ISSUE: begin
                    if (axi_awvalid && axi_awready) begin
                        axi_awvalid <= 1'b0;
                        aw_done     <= 1'b1;
                    end
                    if (axi_wvalid && axi_wready) begin
                        axi_wvalid <= 1'b0;
                        w_done     <= 1'b1;
                    end
                    // wait for the slower of the two channels
                    if (aw_fin && w_fin) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (axi_bvalid) begin
                        wr_done <= 1'b1;
                        wr_err  <= (axi_bresp != RESP_OKAY);
                        state   <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // address and data held for the whole write
    always_ff @(posedge aclk) begin
        if ((state == WR_IDLE) && pkt_done) begin
            axi_awaddr <= req.addr;
            axi_wdata  <= req.data;
        end
    end

endmodule

//--- verif/lite_slave_model.sv
/*
 * AXI-lite write slave for the bridge testbench
 * awready and wready rise at random, the b response follows after a random
 * delay and is SLVERR inside the error window; every finished write is
 * shown for one cycle on rec_valid, rec_req and rec_resp
 */
`timescale 1ns/1ps

module lite_slave_model #(
    parameter int                   SEED   = 71,
    parameter axis_lite_pkg::addr_t ERR_LO = 32'h00F0_0000,
    parameter axis_lite_pkg::addr_t ERR_HI = 32'h00FF_FFFF
) (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      awvalid,
    output logic                      awready,
    input  axis_lite_pkg::addr_t      awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  axis_lite_pkg::wdata_t     wdata,
    output logic                      bvalid,
    output axis_lite_pkg::resp_t      bresp,
    input  logic                      bready,
    output logic                      busy,
    output logic                      rec_valid,
    output axis_lite_pkg::write_req_t rec_req,
    output axis_lite_pkg::resp_t      rec_resp
);
    import axis_lite_pkg::*;

    localparam resp_t RESP_SLVERR = 2'b10;

    integer     seed;
    logic       got_aw;
    logic       got_w;
    logic       bdone;
    write_req_t cur;

    // a write is open from its first phase until b is taken
    assign busy = got_aw || got_w || bvalid;

    initial begin
        seed      = SEED;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        bresp     = RESP_OKAY;
        rec_valid = 1'b0;
        rec_req   = '0;
        rec_resp  = RESP_OKAY;
        got_aw    = 1'b0;
        got_w     = 1'b0;
        cur       = '0;
    end

    always @(posedge aclk) begin
        // handshakes of this edge
        bdone = rst_n && bvalid && bready;
        if (!rst_n || bdone) begin
            got_aw = 1'b0;
            got_w  = 1'b0;
        end else begin
            if (awvalid && awready) begin
                cur.addr = awaddr;
                got_aw   = 1'b1;
            end
            if (wvalid && wready) begin
                cur.data = wdata;
                got_w    = 1'b1;
            end
        end
        #1;
        rec_valid = bdone;
        if (bdone) begin
            rec_req  = cur;
            rec_resp = bresp;
        end
        if (!rst_n || bdone) begin
            bvalid = 1'b0;
        end else if (got_aw && got_w && !bvalid && (($random(seed) & 3) == 0)) begin
            bvalid = 1'b1;
            bresp  = ((cur.addr >= ERR_LO) && (cur.addr <= ERR_HI)) ? RESP_SLVERR : RESP_OKAY;
        end
        // readies drawn independently, dropped once the phase is taken
        awready = rst_n && !got_aw && (($random(seed) & 3) != 0);
        wready  = rst_n && !got_w && (($random(seed) & 1) != 0);
    end

endmodule

//--- verif/tb_axis_to_lite_wr.sv
/*
 * testbench for the byte stream to AXI-lite write bridge with 3 address bytes
 * sends random packets of exact, long, short and mixed length, keeps a queue
 * of expected writes and checks them against what the slave model records
 */
`timescale 1ns/1ps

module tb_axis_to_lite_wr;
    import axis_lite_pkg::*;

    localparam int    ADDR_BYTES  = 3;
    localparam int    FIELD_LEN   = ADDR_BYTES + 4;
    localparam addr_t ADDR_MASK   = 32'h00FF_FFFF;
    // top sixteenth of the 24 bit address space answers SLVERR
    localparam addr_t ERR_LO      = 32'h00F0_0000;
    localparam addr_t ERR_HI      = 32'h00FF_FFFF;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam int    WAIT_LIMIT  = 400;
    localparam int    PKTS        = 30;

    logic       aclk;
    logic       rst_n;
    logic       s_axis_tvalid;
    axis_beat_t s_axis_beat;
    logic       s_axis_tready;
    logic       axi_awvalid, axi_awready, axi_wvalid, axi_wready;
    logic       axi_bvalid, axi_bready;
    addr_t      axi_awaddr;
    wdata_t     axi_wdata;
    resp_t      axi_bresp;
    logic       wr_done, wr_err, short_pkt;
    logic       slave_busy, rec_valid;
    write_req_t rec_req;
    resp_t      rec_resp;

    integer     seed;
    write_req_t exp_q[$];
    bit         exp_err_q[$];
    write_req_t want_req;
    bit         want_err;
    int         errors, checks;
    bit         timed_out;
    // pulses and writes seen and packets sent in the running test
    int         short_cnt, done_cnt, err_cnt, write_cnt;
    int         sent_short, sent_full, sent_err;

    axis_to_lite_wr #(
        .ADDR_BYTES (ADDR_BYTES)
    ) u_dut (
        .aclk (aclk), .rst_n (rst_n),
        .s_axis_tvalid (s_axis_tvalid), .s_axis_beat (s_axis_beat),
        .s_axis_tready (s_axis_tready),
        .axi_awvalid (axi_awvalid), .axi_awready (axi_awready), .axi_awaddr (axi_awaddr),
        .axi_wvalid (axi_wvalid), .axi_wready (axi_wready), .axi_wdata (axi_wdata),
        .axi_bvalid (axi_bvalid), .axi_bresp (axi_bresp), .axi_bready (axi_bready),
        .wr_done (wr_done), .wr_err (wr_err), .short_pkt (short_pkt)
    );

    lite_slave_model #(
        .SEED (71), .ERR_LO (ERR_LO), .ERR_HI (ERR_HI)
    ) u_slave (
        .aclk (aclk), .rst_n (rst_n),
        .awvalid (axi_awvalid), .awready (axi_awready), .awaddr (axi_awaddr),
        .wvalid (axi_wvalid), .wready (axi_wready), .wdata (axi_wdata),
        .bvalid (axi_bvalid), .bresp (axi_bresp), .bready (axi_bready),
        .busy (slave_busy), .rec_valid (rec_valid), .rec_req (rec_req), .rec_resp (rec_resp)
    );

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    task automatic compare_write(input write_req_t got, input write_req_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH %0t: write addr %h data %h, expected addr %h data %h",
                     $time, got.addr, got.data, want.addr, want.data);
        end
    endtask

    task automatic compare_resp(input resp_t got, input resp_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH %0t: bresp %b, expected %b", $time, got, want);
        end
    endtask

    task automatic compare_flag(input int got, input int want, input string what);
        checks++;
        if (got != want) begin
            errors++;
            $display("MISMATCH %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // a wait that ran out stops all further stimulus
    task automatic report_timeout(input string why);
        $display("%0t: %s", $time, why);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic clear_counts();
        short_cnt  = 0;
        done_cnt   = 0;
        err_cnt    = 0;
        write_cnt  = 0;
        sent_short = 0;
        sent_full  = 0;
        sent_err   = 0;
    endtask

    // one beat held until the DUT takes it
    task automatic push_beat(input byte_t data, input logic last);
        int   waited;
        logic ready_seen;
        waited            = 0;
        ready_seen        = 1'b0;
        s_axis_tvalid     = 1'b1;
        s_axis_beat.tdata = data;
        s_axis_beat.tlast = last;
        while (!ready_seen && waited < WAIT_LIMIT) begin
            // tready only moves on rising edges
            @(negedge aclk);
            ready_seen = s_axis_tready;
            @(posedge aclk);
            #1;
            waited++;
        end
        if (!ready_seen) report_timeout("stream beat never accepted, s_axis_tready stayed low");
        s_axis_tvalid = 1'b0;
    endtask

    task automatic send_packet(input addr_t addr, input wdata_t data, input int len);
        byte_t      field [FIELD_LEN];
        write_req_t want;
        int         i;
        int         gap;
        want.addr = addr & ADDR_MASK;
        want.data = data;
        // address then data bytes msb first
        for (i = 0; i < ADDR_BYTES; i++) begin
            field[i] = byte_t'(want.addr >> (8 * (ADDR_BYTES - 1 - i)));
        end
        for (i = 0; i < 4; i++) begin
            field[ADDR_BYTES + i] = byte_t'(data >> (8 * (3 - i)));
        end
        if (len >= FIELD_LEN) begin
            exp_q.push_back(want);
            exp_err_q.push_back((want.addr >= ERR_LO) && (want.addr <= ERR_HI));
            sent_full++;
            if ((want.addr >= ERR_LO) && (want.addr <= ERR_HI)) sent_err++;
        end else begin
            sent_short++;
        end
        for (i = 0; i < len && !timed_out; i++) begin
            gap = $random(seed) & 7;
            if (gap > 4) begin
                repeat (gap - 4) @(posedge aclk);
                #1;
            end
            push_beat((i < FIELD_LEN) ? field[i] : byte_t'($random(seed)), i == len - 1);
        end
    endtask

    task automatic wait_drained();
        int waited;
        bit drained;
        waited  = 0;
        drained = 1'b0;
        while (!drained && waited < WAIT_LIMIT) begin
            @(posedge aclk);
            #1;
            waited++;
            drained = (exp_q.size() == 0) && s_axis_tready && !slave_busy;
        end
        if (!drained) report_timeout("expected writes still missing after the drain timeout");
    endtask

    task automatic run_test(input string name, input int kind);
        int    n;
        int    len;
        int    base;
        addr_t addr;
        base = errors;
        clear_counts();
        for (n = 0; n < PKTS && !timed_out; n++) begin
            addr = addr_t'($random(seed)) & ADDR_MASK;
            case (kind)
                0: len = FIELD_LEN;
                1: len = FIELD_LEN + 1 + ($random(seed) & 7);
                2: len = 1 + (($random(seed) & 32'h7FFF_FFFF) % (FIELD_LEN - 1));
                3: len = 1 + ($random(seed) & 15);
                default: begin
                    len  = FIELD_LEN + ($random(seed) & 3);
                    // every other write goes into the error window
                    addr = n[0] ? (ERR_LO | (addr & 32'h000F_FFFF)) : (addr & 32'h007F_FFFF);
                end
            endcase
            send_packet(addr, wdata_t'($random(seed)), len);
        end
        if (!timed_out) wait_drained();
        compare_flag(short_cnt, sent_short, "short_pkt pulses");
        compare_flag(done_cnt, sent_full, "wr_done pulses");
        compare_flag(err_cnt, sent_err, "wr_err pulses");
        compare_flag(write_cnt, sent_full, "writes seen by the slave");
        $display("test %s: %0d packets, %0d writes, %0d errors",
                 name, PKTS, write_cnt, errors - base);
    endtask

    // outputs are stable on the falling edge
    always @(negedge aclk) begin
        if (rst_n) begin
            if (short_pkt) short_cnt++;
            if (wr_done) done_cnt++;
            if (wr_err) err_cnt++;
            if (!axi_bready) begin
                errors++;
                $display("MISMATCH %0t: axi_bready is low, expected high", $time);
            end
            if (s_axis_tready && (axi_awvalid || axi_wvalid || slave_busy)) begin
                errors++;
                $display("%0t: s_axis_tready is high while a write is pending", $time);
            end
            if (rec_valid) begin
                write_cnt++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%0t: write to %h arrived with no complete packet sent",
                             $time, rec_req.addr);
                end else begin
                    want_req = exp_q.pop_front();
                    want_err = exp_err_q.pop_front();
                    compare_write(rec_req, want_req);
                    compare_resp(rec_resp, want_err ? RESP_SLVERR : RESP_OKAY);
                    // wr_err pulses in the same cycle as this response is recorded
                    compare_flag(int'(wr_err), int'(want_err), "wr_err for this write");
                end
            end
        end
    end

    initial begin
        seed          = 71;
        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        rst_n         = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_beat   = '0;
        clear_counts();
        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        run_test("exact_length", 0);
        run_test("long_packets", 1);
        run_test("short_packets", 2);
        run_test("mixed_lengths", 3);
        run_test("error_window", 4);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
